// File: design/ks10Pkg.sv
/*
 * Shared types and constants for the KS-10 DBUS slice.
 * Holds the 36-bit word type, the microword field layout and the
 * select encodings. Modules pull it in with a wildcard import.
 */

package ks10Pkg;

   ////////////////////////////////////////
   // Data word
   ////////////////////////////////////////

   // Bit 0 is the most significant bit
   typedef logic [0:35] word_t;

   // Width of the microword number field
   localparam int numWidth = 10;

   // Flag bits kept in the left half of the flags word
   localparam int flagWidth = 13;

   ////////////////////////////////////////
   // Microword layout
   ////////////////////////////////////////

   localparam int cromWidth = 32;

   // Low bit of each multi-bit field
   localparam int cromDbusLsb = 0;    // 2 bits
   localparam int cromDbmLsb  = 2;    // 2 bits
   localparam int cromAluLsb  = 4;    // 2 bits
   localparam int cromNumLsb  = 6;    // numWidth bits
   localparam int cromByteLsb = 16;   // 3 bits

   // Single-bit load strobes
   localparam int cromLoadRamBit   = 19;
   localparam int cromLoadFlagsBit = 20;
   localparam int cromLoadDpBit    = 21;

   // Bits 22 to 31 are spare in this slice

   ////////////////////////////////////////
   // Select encodings
   ////////////////////////////////////////

   // DBUS source
   typedef enum logic [1:0] {
      dbusFlags = 2'd0,
      dbusDp    = 2'd1,
      dbusRam   = 2'd2,
      dbusDbm   = 2'd3
   } dbusSel_t;

   // DBM source
   typedef enum logic [1:0] {
      dbmNum  = 2'd0,
      dbmSwap = 2'd1,
      dbmByte = 2'd2,
      dbmMem  = 2'd3
   } dbmSel_t;

   // DP operate function
   typedef enum logic [1:0] {
      aluPass = 2'd0,
      aluAdd  = 2'd1,
      aluAnd  = 2'd2,
      aluOr   = 2'd3
   } aluOp_t;

endpackage

// File: design/cromIf.sv
/*
 * Decoded microword fields shared by the DBUS slice blocks.
 * The top level drives every field through src, and each block
 * reads only its own fields through its modport.
 */

`timescale 1ns/1ps

interface cromIf import ks10Pkg::*; ();

   // Source selects
   dbusSel_t             dbusSel;
   dbmSel_t              dbmSel;
   aluOp_t               aluOp;

   // Number field and byte position
   logic [numWidth-1:0]  num;
   logic [2:0]           bytePos;

   // Per-cycle load strobes
   logic                 loadRam;
   logic                 loadFlags;
   logic                 loadDp;

   // Driven from microword slices
   modport src (
      output dbusSel, dbmSel, aluOp, num, bytePos,
      output loadRam, loadFlags, loadDp
   );

   modport dbusSide (input dbusSel);
   modport dbmSide  (input dbmSel, num, bytePos);
   modport ramSide  (input num, loadRam);
   modport flagSide (input loadFlags);
   modport dpSide   (input aluOp, loadDp);

endinterface

// File: design/dbus.sv
/*
 * DBUS multiplexer. Routes flags, DP, the RAM file or the DBM
 * onto the data bus. Force-ramfile turns a DBM pick into a RAM pick.
 */

`timescale 1ns/1ps

module dbus import ks10Pkg::*; (
   cromIf.dbusSide ifc,
   input  logic    forceRamfile,
   input  word_t   flags,
   input  word_t   dp,
   input  word_t   ram,
   input  word_t   dbm,
   output word_t   busOut
);

   ////////////////////////////////////////
   // Effective select
   ////////////////////////////////////////

   logic [1:0] selBits;
   dbusSel_t   effSel;

   // High bit passes straight through
   // Low bit drops when forcing a DBM pick
   assign selBits = {ifc.dbusSel[1],
                     ifc.dbusSel[0] & ~(ifc.dbusSel[1] & forceRamfile)};
   assign effSel  = dbusSel_t'(selBits);

   ////////////////////////////////////////
   // Source mux
   ////////////////////////////////////////

   always_comb
   begin
      case (effSel)
         dbusFlags: busOut = flags;
         dbusDp:    busOut = dp;
         dbusRam:   busOut = ram;
         dbusDbm:   busOut = dbm;
         default:   busOut = '0;
      endcase
   end

endmodule

// File: design/dbm.sv
/*
 * Data bus mux feeding the DBUS. Picks the number field in both
 * halves, DP with halves swapped, one 7-bit DP byte, or memory data.
 */

`timescale 1ns/1ps

module dbm import ks10Pkg::*; (
   cromIf.dbmSide ifc,
   input  word_t  dp,
   input  word_t  mem,
   output word_t  dbmOut
);

   localparam int halfWidth = 18;
   localparam int byteWidth = 7;

   logic [0:halfWidth-1] numHalf;
   logic [0:byteWidth-1] byteVal;
   word_t                byteWord;

   ////////////////////////////////////////
   // Number field
   ////////////////////////////////////////

   // Zero extended to a half word
   assign numHalf = {{(halfWidth-numWidth){1'b0}}, ifc.num};

   ////////////////////////////////////////
   // Byte extract
   ////////////////////////////////////////

   // Five bytes starting at bit 1
   // Byte 0 is DP bits 1 to 7
   always_comb
   begin
      byteVal = '0;
      if (ifc.bytePos < 3'd5)
      begin
         byteVal = dp[1 + byteWidth * int'(ifc.bytePos) +: byteWidth];
      end
   end

   // Right justified, zero filled
   assign byteWord = {{(36-byteWidth){1'b0}}, byteVal};

   ////////////////////////////////////////
   // Output mux
   ////////////////////////////////////////

   always_comb
   begin
      case (ifc.dbmSel)
         dbmNum:  dbmOut = {numHalf, numHalf};
         dbmSwap: dbmOut = {dp[18:35], dp[0:17]};
         dbmByte: dbmOut = byteWord;
         dbmMem:  dbmOut = mem;
         default: dbmOut = '0;
      endcase
   end

endmodule

// File: design/ramFile.sv
/*
 * RAM file of 36-bit words addressed by the low bits of the number
 * field. Reads are combinational, writes land on the rising clock
 * when loadRam is set, so a same-cycle read sees the old word.
 */

`timescale 1ns/1ps

module ramFile import ks10Pkg::*; #(
   parameter int ramAddrWidth = 4
) (
   input  logic   clk,
   input  logic   arstN,
   cromIf.ramSide ifc,
   input  word_t  bus,
   output word_t  ram
);

   localparam int ramDepth = 2 ** ramAddrWidth;

   ////////////////////////////////////////
   // Storage and address
   ////////////////////////////////////////

   word_t                   words [0:ramDepth-1];
   logic [ramAddrWidth-1:0] addr;

   // Low bits of the number field
   assign addr = ifc.num[ramAddrWidth-1:0];

   ////////////////////////////////////////
   // Write port
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         // Whole file comes up zero
         for (int i = 0; i < ramDepth; i++)
         begin
            words[i] <= '0;
         end
      end
      else if (ifc.loadRam)
      begin
         words[addr] <= bus;
      end
   end

   ////////////////////////////////////////
   // Read port
   ////////////////////////////////////////

   assign ram = words[addr];

endmodule

// File: design/pcFlags.sv
/*
 * PC flags register. Loads the top flag bits from the DBUS left
 * half on loadFlags and shows them back in the left half of flags.
 */

`timescale 1ns/1ps

module pcFlags import ks10Pkg::*; (
   input  logic    clk,
   input  logic    arstN,
   cromIf.flagSide ifc,
   input  word_t   bus,
   output word_t   flags
);

   // Flag bits 0 to 12 only
   logic [0:flagWidth-1] flagReg;

   ////////////////////////////////////////
   // Flag register
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         flagReg <= '0;
      end
      else if (ifc.loadFlags)
      begin
         flagReg <= bus[0:flagWidth-1];
      end
   end

   ////////////////////////////////////////
   // Flags word
   ////////////////////////////////////////

   // No PC in this slice, so the right half stays zero
   assign flags = {flagReg, {(36-flagWidth){1'b0}}};

endmodule

// File: design/dataPath.sv
/*
 * Data path register standing in for the 2901 slices. On loadDp it
 * takes the DBUS itself, or the DBUS combined with the old DP by
 * add, AND or OR, as chosen by the microword ALU field.
 */

`timescale 1ns/1ps

module dataPath import ks10Pkg::*; (
   input  logic  clk,
   input  logic  arstN,
   cromIf.dpSide ifc,
   input  word_t bus,
   output word_t dp
);

   word_t aluOut;

   ////////////////////////////////////////
   // Operate
   ////////////////////////////////////////

   always_comb
   begin
      case (ifc.aluOp)
         // Straight load from DBUS
         aluPass: aluOut = bus;

         // Carry out of bit 0 is dropped
         aluAdd:  aluOut = bus + dp;

         aluAnd:  aluOut = bus & dp;
         aluOr:   aluOut = bus | dp;
         default: aluOut = bus;
      endcase
   end

   ////////////////////////////////////////
   // DP register
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         dp <= '0;
      end
      else if (ifc.loadDp)
      begin
         dp <= aluOut;
      end
   end

endmodule

// File: design/ks10DbusCore.sv
/*
 * Top of the DBUS slice. Slices the incoming microword into the
 * field interface and wires the DBUS, DBM, RAM file, flags and DP.
 */

`timescale 1ns/1ps

module ks10DbusCore import ks10Pkg::*; #(
   parameter int ramAddrWidth = 4
) (
   input  logic                 clk,
   input  logic                 arstN,
   input  logic [cromWidth-1:0] crom,
   input  logic                 forceRamfile,
   input  word_t                mem,
   output word_t                dbusOut,
   output word_t                dpOut
);

   word_t flags;
   word_t dp;
   word_t ram;
   word_t dbmOut;
   word_t busOut;

   cromIf cromBus ();

   ////////////////////////////////////////
   // Microword fields
   ////////////////////////////////////////

   assign cromBus.dbusSel   = dbusSel_t'(crom[cromDbusLsb +: 2]);
   assign cromBus.dbmSel    = dbmSel_t'(crom[cromDbmLsb +: 2]);
   assign cromBus.aluOp     = aluOp_t'(crom[cromAluLsb +: 2]);
   assign cromBus.num       = crom[cromNumLsb +: numWidth];
   assign cromBus.bytePos   = crom[cromByteLsb +: 3];
   assign cromBus.loadRam   = crom[cromLoadRamBit];
   assign cromBus.loadFlags = crom[cromLoadFlagsBit];
   assign cromBus.loadDp    = crom[cromLoadDpBit];

   ////////////////////////////////////////
   // Blocks
   ////////////////////////////////////////

   dbus dbus_inst (.ifc(cromBus), .forceRamfile(forceRamfile), .flags(flags),
                   .dp(dp), .ram(ram), .dbm(dbmOut), .busOut(busOut));

   dbm dbm_inst (.ifc(cromBus), .dp(dp), .mem(mem), .dbmOut(dbmOut));

   // DBUS loops back into every register
   ramFile #(.ramAddrWidth(ramAddrWidth)) ramFile_inst (
      .clk(clk), .arstN(arstN), .ifc(cromBus), .bus(busOut), .ram(ram));

   pcFlags pcFlags_inst (.clk(clk), .arstN(arstN), .ifc(cromBus),
                         .bus(busOut), .flags(flags));

   dataPath dataPath_inst (.clk(clk), .arstN(arstN), .ifc(cromBus),
                           .bus(busOut), .dp(dp));

   assign dbusOut = busOut;
   assign dpOut   = dp;

endmodule

// File: tests/tbKs10DbusCore.sv
/*
 * Testbench for the KS-10 DBUS slice. Replays the stimulus file one
 * microword per clock and checks dbusOut and dpOut in mid-cycle.
 */

`timescale 1ns/1ps

module tbKs10DbusCore import ks10Pkg::*; ();

   localparam int ramAddrWidth = 4;
   localparam int resetCycles  = 3;
   localparam int maxLines     = 500;
   localparam string stimulusPath = "tests/ks10dbus_stimulus.txt";

   // DUT ports
   logic                 clk;
   logic                 arstN;
   logic [cromWidth-1:0] crom;
   logic                 forceRamfile;
   word_t                mem;
   word_t                dbusOut;
   word_t                dpOut;

   // Fields of the current vector
   logic [1:0]           vecDbus;
   logic [1:0]           vecDbm;
   logic [1:0]           vecAlu;
   logic [numWidth-1:0]  vecNum;
   logic [2:0]           vecByte;
   logic                 vecLoadRam;
   logic                 vecLoadFlags;
   logic                 vecLoadDp;
   logic                 vecForce;
   word_t                vecMem;
   word_t                expDbus;
   word_t                expDp;

   // File walk state
   int                   fileHandle;
   int                   lineCount;
   int                   vectorCount;
   int                   fieldCount;
   bit                   endOfFile;
   string                lineText;

   ks10DbusCore #(.ramAddrWidth(ramAddrWidth)) ks10DbusCore_inst (
      .clk(clk), .arstN(arstN), .crom(crom), .forceRamfile(forceRamfile),
      .mem(mem), .dbusOut(dbusOut), .dpOut(dpOut));

   // 40 ns period
   always #20 clk = ~clk;

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   task automatic compareWord(input string name, input word_t actual, input word_t expected);
      if (actual !== expected)
      begin
         $display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
         $display("SOME TESTS FAILED");
         $fatal(1, "Output mismatch");
      end
   endtask

   // Pack the vector fields into a microword and drive it on this edge
   task automatic driveVector();
      logic [cromWidth-1:0] cromWord;
      cromWord = '0;
      cromWord[cromDbusLsb +: 2]       = vecDbus;
      cromWord[cromDbmLsb +: 2]        = vecDbm;
      cromWord[cromAluLsb +: 2]        = vecAlu;
      cromWord[cromNumLsb +: numWidth] = vecNum;
      cromWord[cromByteLsb +: 3]       = vecByte;
      cromWord[cromLoadRamBit]         = vecLoadRam;
      cromWord[cromLoadFlagsBit]       = vecLoadFlags;
      cromWord[cromLoadDpBit]          = vecLoadDp;
      crom         <= cromWord;
      forceRamfile <= vecForce;
      mem          <= vecMem;
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial
   begin
      $timeformat(-9, 0, " ns", 0);
      clk          = 1'b0;
      arstN        = 1'b0;
      crom         = '0;
      forceRamfile = 1'b0;
      mem          = '0;
      lineCount    = 0;
      vectorCount  = 0;
      endOfFile    = 1'b0;

      // Reset held over three rising edges
      for (int i = 0; i < resetCycles; i++)
      begin
         @(posedge clk);
      end
      arstN <= 1'b1;

      fileHandle = $fopen(stimulusPath, "r");
      if (fileHandle == 0)
      begin
         $display("Could not open the stimulus file %s", stimulusPath);
         $display("SOME TESTS FAILED");
         $fatal(1, "Missing stimulus file");
      end

      // One vector per clock until end of file
      while (!endOfFile)
      begin
         if (lineCount >= maxLines)
         begin
            $display("Timed out before the end of the stimulus file");
            $display("SOME TESTS FAILED");
            $fatal(1, "Stimulus timeout");
         end
         lineCount++;
         lineText = "";
         if ($fgets(lineText, fileHandle) == 0)
         begin
            endOfFile = 1'b1;
         end
         else if (lineText.len() > 1 && lineText[0] != "#")
         begin
            fieldCount = $sscanf(lineText, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                 vecDbus, vecDbm, vecAlu, vecNum, vecByte, vecLoadRam,
                                 vecLoadFlags, vecLoadDp, vecForce, vecMem, expDbus, expDp);
            if (fieldCount != 12)
            begin
               $display("Stimulus line %0d does not hold twelve fields", lineCount);
               $display("SOME TESTS FAILED");
               $fatal(1, "Malformed stimulus");
            end
            @(posedge clk);
            driveVector();
            // Inputs and registers settled by mid-cycle
            @(negedge clk);
            compareWord("dbusOut", dbusOut, expDbus);
            compareWord("dpOut", dpOut, expDp);
            vectorCount++;
         end
      end
      $fclose(fileHandle);

      if (vectorCount > 0)
      begin
         $display("ALL TESTS PASSED");
         $finish;
      end
      else
      begin
         $display("The stimulus file held no vectors");
         $display("SOME TESTS FAILED");
         $fatal(1, "Empty stimulus");
      end
   end

endmodule

// File: ks10dbus.f
design/ks10Pkg.sv
design/cromIf.sv
design/dbus.sv
design/dbm.sv
design/ramFile.sv
design/pcFlags.sv
design/dataPath.sv
design/ks10DbusCore.sv
tests/tbKs10DbusCore.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the KS-10 DBUS slice testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simName=simKs10Dbus
logFile=sim.log

if ! verilator --binary --timing -f ks10dbus.f --top-module tbKs10DbusCore \
      -Mdir "$buildDir" -o "$simName"; then
   echo "Verilator build failed"
   exit 1
fi

"./$buildDir/$simName" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if [ "$simStatus" -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi

if grep -q "ALL TESTS PASSED" "$logFile"; then
   echo "Simulation passed"
   exit 0
else
   echo "Pass message not found in $logFile"
   exit 1
fi

// File: tests/ks10dbus_stimulus.txt
# dbusSel dbmSel aluOp num bytePos loadRam loadFlags loadDp force mem expDbus expDp
# All hex, one microword per clock, expected values sampled mid-cycle
0 0 0 000 0 0 0 0 0 000000000 000000000 000000000
1 0 0 000 0 0 0 0 0 000000000 000000000 000000000
2 0 0 005 0 0 0 0 0 000000000 000000000 000000000
3 0 0 155 0 0 0 0 0 000000000 005540155 000000000
3 3 0 000 0 0 0 1 0 123456789 123456789 000000000
3 1 0 000 0 0 0 0 0 000000000 59E2448D1 123456789
3 2 0 000 0 0 0 0 0 000000000 000000012 123456789
3 2 0 000 1 0 0 0 0 000000000 00000001A 123456789
3 2 0 000 2 0 0 0 0 000000000 000000015 123456789
3 2 0 000 3 0 0 0 0 000000000 00000004F 123456789
3 2 0 000 4 0 0 0 0 000000000 000000009 123456789
3 2 0 000 5 0 0 0 0 000000000 000000000 123456789
3 2 0 000 7 0 0 0 0 000000000 000000000 123456789
3 3 0 003 0 1 0 0 0 2468ACE13 2468ACE13 123456789
3 3 0 00A 0 1 0 0 0 2468ACE13 2468ACE13 123456789
3 3 0 01F 0 1 0 0 0 2468ACE13 2468ACE13 123456789
2 0 0 003 0 0 0 0 0 000000000 2468ACE13 123456789
2 0 0 00A 0 0 0 0 0 000000000 2468ACE13 123456789
2 0 0 00F 0 0 0 0 0 000000000 2468ACE13 123456789
2 0 0 004 0 0 0 0 0 000000000 000000000 123456789
3 3 0 003 0 0 0 0 1 FFFFFFFFF 2468ACE13 123456789
3 0 0 003 0 0 0 0 1 000000000 2468ACE13 123456789
1 0 0 000 0 0 0 0 1 000000000 123456789 123456789
2 0 0 00A 0 0 0 0 1 000000000 2468ACE13 123456789
3 3 0 000 0 0 1 0 0 FFFFFFFFF FFFFFFFFF 123456789
0 0 0 000 0 0 0 0 0 000000000 FFF800000 123456789
0 0 0 000 0 0 0 0 1 000000000 FFF800000 123456789
3 3 0 000 0 0 1 0 0 5A5A5A5A5 5A5A5A5A5 123456789
0 0 0 000 0 0 0 0 0 000000000 5A5800000 123456789
3 3 0 000 0 0 0 1 0 FFFFFFFF0 FFFFFFFF0 123456789
3 3 1 000 0 0 0 1 0 000000020 000000020 FFFFFFFF0
3 3 0 000 0 0 0 1 0 0F0F0F0F0 0F0F0F0F0 000000010
3 3 2 000 0 0 0 1 0 0FF00FF00 0FF00FF00 0F0F0F0F0
3 3 3 000 0 0 0 1 0 300003003 300003003 0F000F000
1 0 1 000 0 0 0 1 0 000000000 3F000F003 3F000F003
1 0 0 000 0 0 0 0 0 000000000 7E001E006 7E001E006
2 0 0 003 0 1 0 0 0 000000000 2468ACE13 7E001E006
1 0 0 003 0 1 0 0 0 000000000 7E001E006 7E001E006
2 0 0 003 0 0 0 0 0 000000000 7E001E006 7E001E006
2 0 0 00A 0 0 0 0 0 000000000 2468ACE13 7E001E006
